// ==== common/ecc_pkg.sv ====
package ecc_pkg;

    localparam int DATA_W   = 39;
    localparam int PARITY_W = 7;
    localparam int CODE_W   = DATA_W + PARITY_W;   // check bits sit above the data.
    localparam int DEPTH    = 64;
    localparam int ADDR_W   = $clog2(DEPTH);
    localparam int CNT_W    = 16;

    typedef logic [DATA_W-1:0]   data_t;
    typedef logic [PARITY_W-1:0] parity_t;
    typedef logic [CODE_W-1:0]   code_t;
    typedef logic [ADDR_W-1:0]   addr_t;
    typedef logic [CNT_W-1:0]    cnt_t;

    // check bits of a data word, shared by the write path and the checker.
    function automatic parity_t ecc_encode(input data_t d);
        parity_t p;
        p[0] = d[0] ^ d[1] ^ d[3] ^ d[4] ^ d[6] ^ d[8] ^ d[10] ^ d[11]
             ^ d[13] ^ d[15] ^ d[17] ^ d[19] ^ d[21] ^ d[23] ^ d[25]
             ^ d[26] ^ d[28] ^ d[30] ^ d[32] ^ d[34] ^ d[36] ^ d[38];
        p[1] = d[0] ^ d[2] ^ d[3] ^ d[5] ^ d[6] ^ d[9] ^ d[10] ^ d[12]
             ^ d[13] ^ d[16] ^ d[17] ^ d[20] ^ d[21] ^ d[24] ^ d[25]
             ^ d[27] ^ d[28] ^ d[31] ^ d[32] ^ d[35] ^ d[36];
        p[2] = d[1] ^ d[2] ^ d[3] ^ d[7] ^ d[8] ^ d[9] ^ d[10] ^ d[14]
             ^ d[15] ^ d[16] ^ d[17] ^ d[22] ^ d[23] ^ d[24] ^ d[25]
             ^ d[29] ^ d[30] ^ d[31] ^ d[32] ^ d[37] ^ d[38];
        p[3] = (^d[10:4]) ^ (^d[25:18]) ^ (^d[38:33]);
        p[4] = ^d[25:11];
        p[5] = ^d[38:26];
        // overall-style bit, breaks the tie between single and double hits.
        p[6] = d[0] ^ d[1] ^ d[2] ^ d[4] ^ d[5] ^ d[7] ^ d[10] ^ d[11]
             ^ d[12] ^ d[14] ^ d[17] ^ d[18] ^ d[21] ^ d[23] ^ d[24]
             ^ d[26] ^ d[27] ^ d[29] ^ d[32] ^ d[33] ^ d[36] ^ d[38];
        return p;
    endfunction

endpackage

// ==== ecc/ecc_39_cal.sv ====
`timescale 1ns/1ps

module ecc_39_cal (
    input  ecc_pkg::data_t   data_in,
    input  ecc_pkg::parity_t parity_in,
    input  logic             bypass,
    output ecc_pkg::data_t   data_out,
    output ecc_pkg::parity_t parity_out,
    output ecc_pkg::data_t   mask,
    output logic             sbit_err,
    output logic             dbit_err
);
    import ecc_pkg::*;

    parity_t                     syndrome;
    logic                        hit;        // syndrome names a data bit.
    logic [$clog2(DATA_W)-1:0]   hit_bit;
    logic [1:0]                  err_class;  // bit 0 single, bit 1 double.

    assign parity_out = ecc_encode(data_in);
    assign syndrome   = parity_in ^ parity_out;

    // syndrome to data-bit column.
    always_comb begin
        hit     = 1'b1;
        hit_bit = '0;
        case (syndrome)
            7'b1000011: hit_bit = 6'd0;
            7'b1000101: hit_bit = 6'd1;
            7'b1000110: hit_bit = 6'd2;
            7'b0000111: hit_bit = 6'd3;
            7'b1001001: hit_bit = 6'd4;
            7'b1001010: hit_bit = 6'd5;
            7'b0001011: hit_bit = 6'd6;
            7'b1001100: hit_bit = 6'd7;
            7'b0001101: hit_bit = 6'd8;
            7'b0001110: hit_bit = 6'd9;
            7'b1001111: hit_bit = 6'd10;
            7'b1010001: hit_bit = 6'd11;
            7'b1010010: hit_bit = 6'd12;
            7'b0010011: hit_bit = 6'd13;
            7'b1010100: hit_bit = 6'd14;
            7'b0010101: hit_bit = 6'd15;
            7'b0010110: hit_bit = 6'd16;
            7'b1010111: hit_bit = 6'd17;
            7'b1011000: hit_bit = 6'd18;
            7'b0011001: hit_bit = 6'd19;
            7'b0011010: hit_bit = 6'd20;
            7'b1011011: hit_bit = 6'd21;
            7'b0011100: hit_bit = 6'd22;
            7'b1011101: hit_bit = 6'd23;
            7'b1011110: hit_bit = 6'd24;
            7'b0011111: hit_bit = 6'd25;
            7'b1100001: hit_bit = 6'd26;
            7'b1100010: hit_bit = 6'd27;
            7'b0100011: hit_bit = 6'd28;
            7'b1100100: hit_bit = 6'd29;
            7'b0100101: hit_bit = 6'd30;
            7'b0100110: hit_bit = 6'd31;
            7'b1100111: hit_bit = 6'd32;
            7'b1101000: hit_bit = 6'd33;
            7'b0101001: hit_bit = 6'd34;
            7'b0101010: hit_bit = 6'd35;
            7'b1101011: hit_bit = 6'd36;
            7'b0101100: hit_bit = 6'd37;
            7'b1101101: hit_bit = 6'd38;
            default:    hit = 1'b0;  // clean, check-bit hit or double.
        endcase
    end

    assign mask = hit ? (data_t'(1) << hit_bit) : '0;

    always_comb begin
        if (syndrome == '0) begin
            err_class = 2'b00;
        end else if (hit || $onehot(syndrome)) begin
            // a lone syndrome bit means the check field itself was hit.
            err_class = 2'b01;
        end else begin
            err_class = 2'b10;
        end
    end

    assign data_out = bypass ? data_in : (data_in ^ mask);
    assign sbit_err = bypass ? 1'b0 : err_class[0];
    assign dbit_err = bypass ? 1'b0 : err_class[1];

endmodule

// ==== verilog/ecc_mem_array.sv ====
`timescale 1ns/1ps

module ecc_mem_array (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wr_en,
    input  logic           rd_en,
    input  ecc_pkg::addr_t addr,
    input  ecc_pkg::data_t wr_data,
    input  ecc_pkg::code_t wr_flip,
    output logic           rd_valid,
    output ecc_pkg::code_t rd_code,
    output ecc_pkg::addr_t rd_addr
);
    import ecc_pkg::*;

    code_t mem [DEPTH];
    code_t wr_code;

    // codeword with injected flips.
    assign wr_code = {ecc_encode(wr_data), wr_data} ^ wr_flip;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[addr] <= wr_code;
        end
    end

    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_code <= mem[addr];   // old word on a same-address write.
            rd_addr <= addr;
        end
    end

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            rd_valid <= 1'b0;
        end else begin
            rd_valid <= rd_en;
        end
    end

    // a result only ever follows a read request.
    a_valid_needs_rd_en : assert property (
        @(posedge clk) disable iff (!rst_n) !rd_en |=> !rd_valid
    ) else $error("rd_valid without a preceding rd_en");

endmodule

// ==== verilog/ecc_err_log.sv ====
`timescale 1ns/1ps

module ecc_err_log (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           rd_valid,
    input  logic           sbit_err,
    input  logic           dbit_err,
    input  logic           clear_log,
    input  ecc_pkg::addr_t rd_addr,
    output ecc_pkg::cnt_t  sbit_count,
    output ecc_pkg::cnt_t  dbit_count,
    output logic           err_valid,
    output ecc_pkg::addr_t err_addr
);
    import ecc_pkg::*;

    logic sbit_hit;
    logic dbit_hit;

    assign sbit_hit = rd_valid & sbit_err;
    assign dbit_hit = rd_valid & dbit_err;

    // holds at all-ones.
    function automatic cnt_t sat_inc(input cnt_t cnt, input logic inc);
        cnt_t nxt;
        nxt = cnt;
        if (inc && cnt != '1) begin
            nxt = cnt + 1'b1;
        end
        return nxt;
    endfunction

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            sbit_count <= '0;
            dbit_count <= '0;
            err_valid  <= 1'b0;
            err_addr   <= '0;
        end else if (clear_log) begin
            // clear wins over a flagged read in the same cycle.
            sbit_count <= '0;
            dbit_count <= '0;
            err_valid  <= 1'b0;
        end else begin
            sbit_count <= sat_inc(sbit_count, sbit_hit);
            dbit_count <= sat_inc(dbit_count, dbit_hit);
            if ((sbit_hit || dbit_hit) && !err_valid) begin
                err_valid <= 1'b1;
                err_addr  <= rd_addr;   // first error only.
            end
        end
    end

    a_sbit_count_mono : assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(clear_log) |-> sbit_count >= $past(sbit_count)
    ) else $error("sbit_count went down without a clear");

    a_dbit_count_mono : assert property (
        @(posedge clk) disable iff (!rst_n)
        $past(rst_n) && !$past(clear_log) |-> dbit_count >= $past(dbit_count)
    ) else $error("dbit_count went down without a clear");

endmodule

// ==== verilog/ecc_mem_top.sv ====
`timescale 1ns/1ps

module ecc_mem_top (
    input  logic             clk,
    input  logic             rst_n,
    input  logic             wr_en,
    input  logic             rd_en,
    input  ecc_pkg::addr_t   addr,
    input  ecc_pkg::data_t   wr_data,
    input  ecc_pkg::code_t   wr_flip,
    input  logic             bypass,
    input  logic             clear_log,
    output logic             rd_valid,
    output ecc_pkg::data_t   rd_data,
    output ecc_pkg::parity_t rd_parity,
    output logic             sbit_err,
    output logic             dbit_err,
    output ecc_pkg::cnt_t    sbit_count,
    output ecc_pkg::cnt_t    dbit_count,
    output logic             err_valid,
    output ecc_pkg::addr_t   err_addr
);
    import ecc_pkg::*;

    code_t rd_code;
    addr_t rd_addr;     // address of the word now at the checker.
    data_t cal_mask;
    logic  cal_bypass;

    // no read in hand means no flags.
    assign cal_bypass = bypass | ~rd_valid;

    ecc_mem_array u_array (
        .clk      (clk),
        .rst_n    (rst_n),
        .wr_en    (wr_en),
        .rd_en    (rd_en),
        .addr     (addr),
        .wr_data  (wr_data),
        .wr_flip  (wr_flip),
        .rd_valid (rd_valid),
        .rd_code  (rd_code),
        .rd_addr  (rd_addr)
    );

    ecc_39_cal u_cal (
        .data_in    (rd_code[DATA_W-1:0]),
        .parity_in  (rd_code[CODE_W-1:DATA_W]),
        .bypass     (cal_bypass),
        .data_out   (rd_data),
        .parity_out (rd_parity),
        .mask       (cal_mask),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err)
    );

    // checker properties, sampled here since the checker has no clock.
    a_mask_onehot0 : assert property (
        @(posedge clk) disable iff (!rst_n) rd_valid |-> $onehot0(cal_mask)
    ) else $error("correction mask has more than one bit set");

    a_flags_exclusive : assert property (
        @(posedge clk) disable iff (!rst_n) !(sbit_err && dbit_err)
    ) else $error("sbit_err and dbit_err both high");

    ecc_err_log u_log (
        .clk        (clk),
        .rst_n      (rst_n),
        .rd_valid   (rd_valid),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .clear_log  (clear_log),
        .rd_addr    (rd_addr),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count),
        .err_valid  (err_valid),
        .err_addr   (err_addr)
    );

endmodule

// ==== sim/ecc_mem_tb.sv ====
`timescale 1ns/1ps

module ecc_mem_tb;
    import ecc_pkg::*;

    localparam int    CLK_PERIOD   = 100;
    localparam int    DRIVE_DLY    = 1;
    localparam int    RESET_CYCLES = 10;
    localparam int    MAX_WAIT     = 8;     // cycles allowed for rd_valid.
    localparam int    N_RAND       = 32;
    localparam int    MARGIN       = 50;
    localparam string STIM_FILE    = "sim/ecc_mem_stimulus.txt";

    logic    clk;
    logic    rst_n;
    logic    wr_en;
    logic    rd_en;
    addr_t   addr;
    data_t   wr_data;
    code_t   wr_flip;
    logic    bypass;
    logic    clear_log;
    logic    rd_valid;
    data_t   rd_data;
    parity_t rd_parity;
    logic    sbit_err;
    logic    dbit_err;
    cnt_t    sbit_count;
    cnt_t    dbit_count;
    logic    err_valid;
    addr_t   err_addr;

    // one entry per stimulus line.
    logic [63:0] op_q[$];
    logic [63:0] addr_q[$];
    logic [63:0] data_q[$];
    logic [63:0] flip_q[$];
    logic [63:0] byp_q[$];
    logic [63:0] exp_data_q[$];
    logic [63:0] exp_sb_q[$];
    logic [63:0] exp_db_q[$];
    logic [63:0] exp_sc_q[$];
    logic [63:0] exp_dc_q[$];

    data_t model_raw [DEPTH];   // stored data bits after injection.
    logic  model_err_valid;
    addr_t model_err_addr;
    logic  loaded;
    int    errors;

    ecc_mem_top dut (
        .clk        (clk),
        .rst_n      (rst_n),
        .wr_en      (wr_en),
        .rd_en      (rd_en),
        .addr       (addr),
        .wr_data    (wr_data),
        .wr_flip    (wr_flip),
        .bypass     (bypass),
        .clear_log  (clear_log),
        .rd_valid   (rd_valid),
        .rd_data    (rd_data),
        .rd_parity  (rd_parity),
        .sbit_err   (sbit_err),
        .dbit_err   (dbit_err),
        .sbit_count (sbit_count),
        .dbit_count (dbit_count),
        .err_valid  (err_valid),
        .err_addr   (err_addr)
    );

    always #(CLK_PERIOD / 2) clk = ~clk;

    // bit k of a data bit's H-matrix column is set when p[k] covers that bit.
    function automatic parity_t column_of(input int i);
        case (i)
            0:  return 7'b1000011;
            1:  return 7'b1000101;
            2:  return 7'b1000110;
            3:  return 7'b0000111;
            4:  return 7'b1001001;
            5:  return 7'b1001010;
            6:  return 7'b0001011;
            7:  return 7'b1001100;
            8:  return 7'b0001101;
            9:  return 7'b0001110;
            10: return 7'b1001111;
            11: return 7'b1010001;
            12: return 7'b1010010;
            13: return 7'b0010011;
            14: return 7'b1010100;
            15: return 7'b0010101;
            16: return 7'b0010110;
            17: return 7'b1010111;
            18: return 7'b1011000;
            19: return 7'b0011001;
            20: return 7'b0011010;
            21: return 7'b1011011;
            22: return 7'b0011100;
            23: return 7'b1011101;
            24: return 7'b1011110;
            25: return 7'b0011111;
            26: return 7'b1100001;
            27: return 7'b1100010;
            28: return 7'b0100011;
            29: return 7'b1100100;
            30: return 7'b0100101;
            31: return 7'b0100110;
            32: return 7'b1100111;
            33: return 7'b1101000;
            34: return 7'b0101001;
            35: return 7'b0101010;
            36: return 7'b1101011;
            37: return 7'b0101100;
            38: return 7'b1101101;
            default: return 7'b0000000;
        endcase
    endfunction

    function automatic parity_t expected_parity(input data_t d);
        parity_t p;
        p = '0;
        for (int i = 0; i < DATA_W; i++) begin
            if (d[i]) p ^= column_of(i);
        end
        return p;
    endfunction

    function automatic logic [31:0] xorshift32(input logic [31:0] s);
        logic [31:0] x;
        x = s;
        x ^= x << 13;
        x ^= x >> 17;
        x ^= x << 5;
        return x;
    endfunction

    task automatic abort_run();
        $display("Some tests failed");
        $fatal(1, "run stopped at the first failure");
    endtask

    task automatic check_value(input string name, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("** Error: %s = 0x%h, expected 0x%h", name, got, exp);
            errors++;
            abort_run();
        end
    endtask

    task automatic next_cycle();
        @(posedge clk);
        #DRIVE_DLY;
    endtask

    task automatic check_log_state(input cnt_t exp_sc, input cnt_t exp_dc);
        check_value("sbit_count", sbit_count, exp_sc);
        check_value("dbit_count", dbit_count, exp_dc);
        check_value("err_valid", err_valid, model_err_valid);
        if (model_err_valid) check_value("err_addr", err_addr, model_err_addr);
    endtask

    task automatic write_word(input addr_t a, input data_t d, input code_t f);
        addr    = a;
        wr_data = d;
        wr_flip = f;
        wr_en   = 1'b1;
        next_cycle();
        wr_en   = 1'b0;
        wr_flip = '0;
        model_raw[a] = d ^ f[DATA_W-1:0];
    endtask

    task automatic read_word(input addr_t a, input logic byp, input data_t exp_d,
                             input logic exp_sb, input logic exp_db,
                             input cnt_t exp_sc, input cnt_t exp_dc);
        int waited;
        addr   = a;
        bypass = byp;   // held until the result has been checked.
        rd_en  = 1'b1;
        next_cycle();
        rd_en  = 1'b0;
        waited = 1;
        while (!rd_valid && waited < MAX_WAIT) begin
            next_cycle();
            waited++;
        end
        if (!rd_valid) begin
            $display("rd_valid never rose after a read of address 0x%h", a);
            abort_run();
        end
        check_value("rd_valid latency", waited, 1);
        check_value("rd_data", rd_data, exp_d);
        check_value("rd_parity", rd_parity, expected_parity(model_raw[a]));
        check_value("sbit_err", sbit_err, exp_sb);
        check_value("dbit_err", dbit_err, exp_db);
        if ((exp_sb || exp_db) && !model_err_valid) begin
            model_err_valid = 1'b1;
            model_err_addr  = a;
        end
        next_cycle();   // log updates one edge after the result.
        bypass = 1'b0;
        check_value("rd_valid", rd_valid, 1'b0);
        // the stored word is still at the checker, the flags must stay quiet.
        check_value("sbit_err", sbit_err, 1'b0);
        check_value("dbit_err", dbit_err, 1'b0);
        check_log_state(exp_sc, exp_dc);
    endtask

    task automatic clear_pulse(input cnt_t exp_sc, input cnt_t exp_dc);
        clear_log = 1'b1;
        next_cycle();
        clear_log = 1'b0;
        model_err_valid = 1'b0;
        check_log_state(exp_sc, exp_dc);
    endtask

    task automatic idle_cycle(input cnt_t exp_sc, input cnt_t exp_dc);
        next_cycle();
        check_log_state(exp_sc, exp_dc);
    endtask

    task automatic load_stimulus();
        int fd;
        int n;
        logic [63:0]       op;
        logic [63:0]       f [9];
        logic [8*256-1:0]  rest;
        fd = $fopen(STIM_FILE, "r");
        if (fd == 0) begin
            $display("cannot open the stimulus file %s", STIM_FILE);
            abort_run();
        end
        while (!$feof(fd)) begin
            n = $fscanf(fd, "%s", op);
            if (n == 1 && op == "#") begin
                n = $fgets(rest, fd);   // comment line.
            end else if (n == 1) begin
                n = $fscanf(fd, "%h %h %h %h %h %h %h %h %h",
                            f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8]);
                if (n != 9) begin
                    $display("stimulus line %0d is malformed", op_q.size());
                    abort_run();
                end
                op_q.push_back(op);
                addr_q.push_back(f[0]);
                data_q.push_back(f[1]);
                flip_q.push_back(f[2]);
                byp_q.push_back(f[3]);
                exp_data_q.push_back(f[4]);
                exp_sb_q.push_back(f[5]);
                exp_db_q.push_back(f[6]);
                exp_sc_q.push_back(f[7]);
                exp_dc_q.push_back(f[8]);
            end
        end
        $fclose(fd);
    endtask

    initial begin
        longint limit;
        wait (loaded);
        limit = RESET_CYCLES + op_q.size() * (MAX_WAIT + 3)
              + N_RAND * (2 * MAX_WAIT + 4) + MARGIN;
        #(limit * CLK_PERIOD);
        $display("timeout: the run did not finish within %0d clock cycles", limit);
        abort_run();
    end

    initial begin
        logic [31:0] rng;
        logic [31:0] hi;
        logic [31:0] lo;
        data_t       d;
        addr_t       a;
        cnt_t        last_sc;
        cnt_t        last_dc;
        clk             = 1'b0;
        rst_n           = 1'b0;
        wr_en           = 1'b0;
        rd_en           = 1'b0;
        addr            = '0;
        wr_data         = '0;
        wr_flip         = '0;
        bypass          = 1'b0;
        clear_log       = 1'b0;
        model_err_valid = 1'b0;
        model_err_addr  = '0;
        loaded          = 1'b0;
        errors          = 0;
        last_sc         = '0;
        last_dc         = '0;
        rng             = 32'he46ca336;

        load_stimulus();
        if (op_q.size() == 0) begin
            $display("the stimulus file holds no operations");
            abort_run();
        end
        loaded = 1'b1;

        repeat (RESET_CYCLES) @(posedge clk);
        #DRIVE_DLY;
        rst_n = 1'b1;
        check_value("rd_valid", rd_valid, 1'b0);
        check_value("err_addr", err_addr, 0);
        check_log_state('0, '0);

        // directed operations from the file.
        for (int i = 0; i < op_q.size(); i++) begin
            if (op_q[i] == "write") begin
                write_word(addr_t'(addr_q[i]), data_t'(data_q[i]), code_t'(flip_q[i]));
            end else if (op_q[i] == "read") begin
                read_word(addr_t'(addr_q[i]), byp_q[i][0], data_t'(exp_data_q[i]),
                          exp_sb_q[i][0], exp_db_q[i][0],
                          cnt_t'(exp_sc_q[i]), cnt_t'(exp_dc_q[i]));
            end else if (op_q[i] == "clear") begin
                clear_pulse(cnt_t'(exp_sc_q[i]), cnt_t'(exp_dc_q[i]));
            end else if (op_q[i] == "idle") begin
                idle_cycle(cnt_t'(exp_sc_q[i]), cnt_t'(exp_dc_q[i]));
            end else begin
                $display("stimulus line %0d has an unknown operation", i);
                abort_run();
            end
            if (op_q[i] != "write") begin
                last_sc = cnt_t'(exp_sc_q[i]);
                last_dc = cnt_t'(exp_dc_q[i]);
            end
        end

        // clean random words must come back untouched.
        for (int k = 0; k < N_RAND; k++) begin
            rng = xorshift32(rng);
            hi  = rng;
            rng = xorshift32(rng);
            lo  = rng;
            d   = {hi[DATA_W-33:0], lo};
            a   = hi[ADDR_W+7:8];
            write_word(a, d, '0);
            read_word(a, 1'b0, d, 1'b0, 1'b0, last_sc, last_dc);
        end

        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// ==== ecc_mem.f ====
common/ecc_pkg.sv
ecc/ecc_39_cal.sv
verilog/ecc_mem_array.sv
verilog/ecc_err_log.sv
verilog/ecc_mem_top.sv
sim/ecc_mem_tb.sv

// ==== Bender.yml ====
package:
  name: ecc_mem

sources:
  # shared package first, the RTL depends on it.
  - common/ecc_pkg.sv
  - ecc/ecc_39_cal.sv
  - verilog/ecc_mem_array.sv
  - verilog/ecc_err_log.sv
  - verilog/ecc_mem_top.sv

  - target: simulation
    files:
      - sim/ecc_mem_tb.sv

// ==== sim/ecc_mem_stimulus.txt ====
# op    addr data       flip         byp exp_data   sb db scnt dcnt
# fields in hex, flip bit 39 and up hit the check bits, expected fields unused on writes
# clean words
write   00   0123456789 000000000000 0   0000000000 0  0  0000 0000
read    00   0000000000 000000000000 0   0123456789 0  0  0000 0000
write   01   7fffffffff 000000000000 0   0000000000 0  0  0000 0000
read    01   0000000000 000000000000 0   7fffffffff 0  0  0000 0000
write   02   0000000000 000000000000 0   0000000000 0  0  0000 0000
read    02   0000000000 000000000000 0   0000000000 0  0  0000 0000
idle    00   0000000000 000000000000 0   0000000000 0  0  0000 0000
# single data-bit flips, bits 0, 17, 38 and 25
write   03   2aaaaaaaaa 000000000001 0   0000000000 0  0  0000 0000
read    03   0000000000 000000000000 0   2aaaaaaaaa 1  0  0001 0000
write   04   1555555555 000000020000 0   0000000000 0  0  0000 0000
read    04   0000000000 000000000000 0   1555555555 1  0  0002 0000
write   05   3c3c3c3c3c 004000000000 0   0000000000 0  0  0000 0000
read    05   0000000000 000000000000 0   3c3c3c3c3c 1  0  0003 0000
write   06   0f0f0f0f0f 000002000000 0   0000000000 0  0  0000 0000
read    06   0000000000 000000000000 0   0f0f0f0f0f 1  0  0004 0000
# single check-bit flips, check bits 0 and 6
write   07   1234567890 008000000000 0   0000000000 0  0  0000 0000
read    07   0000000000 000000000000 0   1234567890 1  0  0005 0000
write   08   6db6db6db6 200000000000 0   0000000000 0  0  0000 0000
read    08   0000000000 000000000000 0   6db6db6db6 1  0  0006 0000
# double flips come back raw
write   09   0123456789 000000000003 0   0000000000 0  0  0000 0000
read    09   0000000000 000000000000 0   012345678a 0  1  0006 0001
write   0a   5a5a5a5a5a 008000000001 0   0000000000 0  0  0000 0000
read    0a   0000000000 000000000000 0   5a5a5a5a5b 0  1  0006 0002
write   0b   7777777777 030000000000 0   0000000000 0  0  0000 0000
read    0b   0000000000 000000000000 0   7777777777 0  1  0006 0003
# bypass returns raw data, no flags, no counts
read    03   0000000000 000000000000 1   2aaaaaaaab 0  0  0006 0003
read    09   0000000000 000000000000 1   012345678a 0  0  0006 0003
read    07   0000000000 000000000000 1   1234567890 0  0  0006 0003
idle    00   0000000000 000000000000 0   0000000000 0  0  0006 0003
# clear, then the next error is captured again
clear   00   0000000000 000000000000 0   0000000000 0  0  0000 0000
idle    00   0000000000 000000000000 0   0000000000 0  0  0000 0000
read    00   0000000000 000000000000 0   0123456789 0  0  0000 0000
read    0a   0000000000 000000000000 0   5a5a5a5a5b 0  1  0000 0001
read    04   0000000000 000000000000 0   1555555555 1  0  0001 0001
clear   00   0000000000 000000000000 0   0000000000 0  0  0000 0000
read    05   0000000000 000000000000 0   3c3c3c3c3c 1  0  0001 0000
# overwrite a flipped word with a clean one
write   03   2aaaaaaaaa 000000000000 0   0000000000 0  0  0000 0000
read    03   0000000000 000000000000 0   2aaaaaaaaa 0  0  0001 0000
idle    00   0000000000 000000000000 0   0000000000 0  0  0001 0000
